// File: source/cpu_pkg.sv
// shared types, opcodes, ALU commands and lookup tables for the 8-bit processor; import in each block
`default_nettype none

package cpu_pkg;

  typedef logic [7:0] word_t;          // datapath byte
  typedef logic [8:0] instr_t;         // machine code word
  typedef logic [2:0] reg_addr_t;      // register index
  typedef logic [7:0] mem_addr_t;      // data memory address
  typedef logic signed [7:0] offset_t; // relative branch distance

  // top three bits of the machine word
  typedef enum logic [2:0] {
    LDI = 3'd0,  // r0 <- imm6
    MOV = 3'd1,  // r[a] <- r[b]
    ADD = 3'd2,  // r[a] <- r[a] + r[b], carry to sc
    XOR = 3'd3,  // r[a] <- r[a] ^ r[b]
    SHF = 3'd4,  // b: 0 left, 1 right, 2 clear sc
    LD  = 3'd5,  // r[a] <- mem[mem_lut[b]]
    ST  = 3'd6,  // mem[mem_lut[b]] <- r[a]
    CTL = 3'd7   // a: 0 halt, 1 out, 2 bnz, 3 bra
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_XOR   = 3'd1,
    ALU_SHL   = 3'd2,
    ALU_SHR   = 3'd3,
    ALU_PASSB = 3'd4
  } alu_cmd_e;

  // machine word split into its fields
  typedef struct packed {
    opcode_e   op;
    reg_addr_t a;
    reg_addr_t b;
  } instr_fields_t;

  // load/store address table, indexed by field b
  localparam mem_addr_t mem_lut [0:7] = '{
    8'd0, 8'd1, 8'd2, 8'd3, 8'd16, 8'd32, 8'd128, 8'd255
  };

  // branch offset table, indexed by field b
  localparam offset_t branch_lut [0:7] = '{
    -8'sd1, -8'sd2, -8'sd3, -8'sd4, 8'sd2, 8'sd3, 8'sd4, 8'sd8
  };

endpackage

`default_nettype wire

// File: source/prog_ctr.sv
// program counter with run/halt state; restarts on req and steps or branches each running cycle
`default_nettype none

module prog_ctr #(
  parameter int PC_W = 6
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            req,        // start pulse from host
  input  wire logic            halt,       // from decode, already gated by run
  input  wire logic            branch_en,
  input  wire cpu_pkg::offset_t branch_off,
  output logic [PC_W-1:0]      pc,
  output logic                 run
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run <= 1'b0;
      pc  <= '0;
    end else if (req) begin
      run <= 1'b1; // restart from address 0
      pc  <= '0;
    end else if (run) begin
      if (halt)
        run <= 1'b0;                     // pc stays on the halt
      else if (branch_en)
        pc <= pc + PC_W'(branch_off);    // sign-extended relative jump
      else
        pc <= pc + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/instr_mem.sv
// instruction memory; host writes programs through the load port, pc reads combinationally
`default_nettype none

module instr_mem #(
  parameter int PC_W = 6
) (
  input  wire logic            clk,
  input  wire logic            load_en,    // host write strobe, idle only
  input  wire logic [PC_W-1:0] load_addr,
  input  wire cpu_pkg::instr_t load_instr,
  input  wire logic [PC_W-1:0] pc,
  output cpu_pkg::instr_t      instr
);
  import cpu_pkg::*;

  instr_t mem [2**PC_W]; // program store, no reset

  always_ff @(posedge clk) begin
    if (load_en)
      mem[load_addr] <= load_instr;
  end

  // fetch in the same cycle
  assign instr = mem[pc];

endmodule

`default_nettype wire

// File: source/ctrl_decode.sv
// machine code decoder; drives register, ALU, memory, branch and output controls, all gated by run
`default_nettype none

module ctrl_decode (
  input  wire cpu_pkg::instr_t  instr,
  input  wire logic             run,
  input  wire logic             zero_q,     // registered zero flag
  output cpu_pkg::reg_addr_t    rd_a,
  output cpu_pkg::reg_addr_t    rd_b,
  output cpu_pkg::reg_addr_t    wr_addr,
  output logic                  reg_we,
  output cpu_pkg::alu_cmd_e     alu_cmd,
  output logic                  imm_sel,    // write back the immediate
  output cpu_pkg::word_t        imm,
  output logic                  mem_sel,    // write back memory data
  output cpu_pkg::mem_addr_t    mem_addr,
  output logic                  mem_we,
  output logic                  branch_en,
  output cpu_pkg::offset_t      branch_off,
  output logic                  halt,
  output logic                  out_en
);
  import cpu_pkg::*;

  instr_fields_t f;

  assign f = instr_fields_t'(instr);

  // fixed field routing
  assign rd_a       = f.a;
  assign rd_b       = f.b;   // also the OUT source
  assign imm        = {2'b00, instr[5:0]};
  assign mem_addr   = mem_lut[f.b];
  assign branch_off = branch_lut[f.b];

  always_comb begin
    wr_addr   = f.a;
    reg_we    = 1'b0;
    alu_cmd   = ALU_PASSB;
    imm_sel   = 1'b0;
    mem_sel   = 1'b0;
    mem_we    = 1'b0;
    branch_en = 1'b0;
    halt      = 1'b0;
    out_en    = 1'b0;
    if (run) begin // idle machine issues nothing
      unique case (f.op)
        LDI: begin
          wr_addr = 3'd0; // always r0
          imm_sel = 1'b1;
          reg_we  = 1'b1;
        end
        MOV: reg_we = 1'b1; // pass b through the ALU
        ADD: begin
          alu_cmd = ALU_ADD;
          reg_we  = 1'b1;
        end
        XOR: begin
          alu_cmd = ALU_XOR;
          reg_we  = 1'b1;
        end
        SHF: begin
          if (f.b == 3'd0) begin
            alu_cmd = ALU_SHL;
            reg_we  = 1'b1;
          end else if (f.b == 3'd1) begin
            alu_cmd = ALU_SHR;
            reg_we  = 1'b1;
          end
          // b=2 clears sc in the top level, other b values do nothing
        end
        LD: begin
          mem_sel = 1'b1;
          reg_we  = 1'b1;
        end
        ST:  mem_we = 1'b1; // data from port a
        CTL: begin
          unique case (f.a)
            3'd0:    halt      = 1'b1;
            3'd1:    out_en    = 1'b1;
            3'd2:    branch_en = !zero_q; // branch on nonzero
            3'd3:    branch_en = 1'b1;
            default: ;                    // reserved, acts as nop
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/reg_file.sv
// eight 8-bit registers; two combinational read ports, one clocked write port
`default_nettype none

module reg_file (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               we,
  input  wire cpu_pkg::reg_addr_t rd_a,
  input  wire cpu_pkg::reg_addr_t rd_b,
  input  wire cpu_pkg::reg_addr_t wr_addr,
  input  wire cpu_pkg::word_t     wr_data,
  output cpu_pkg::word_t          dat_a,
  output cpu_pkg::word_t          dat_b
);
  import cpu_pkg::*;

  word_t regs [8];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0; // all registers start at zero
    end else if (we) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign dat_a = regs[rd_a]; // operand a, store data
  assign dat_b = regs[rd_b]; // operand b, OUT data

endmodule

`default_nettype wire

// File: source/alu.sv
// combinational ALU; add, xor, shifts through carry and pass, with carry and zero outputs
`default_nettype none

module alu (
  input  wire cpu_pkg::alu_cmd_e alu_cmd,
  input  wire cpu_pkg::word_t    in_a,
  input  wire cpu_pkg::word_t    in_b,
  input  wire logic              sc_in,   // registered shift/carry flag
  output cpu_pkg::word_t         rslt,
  output logic                   sc_out,  // new carry or shifted-out bit
  output logic                   zero
);
  import cpu_pkg::*;

  always_comb begin
    rslt   = in_b;
    sc_out = 1'b0;
    unique case (alu_cmd)
      ALU_ADD: {sc_out, rslt} = {1'b0, in_a} + {1'b0, in_b}; // no carry in
      ALU_XOR: rslt = in_a ^ in_b;
      // sc enters bit 0, msb leaves to sc
      ALU_SHL: {sc_out, rslt} = {in_a, sc_in};
      // sc enters bit 7, lsb leaves to sc
      ALU_SHR: {rslt, sc_out} = {sc_in, in_a};
      ALU_PASSB: rslt = in_b; // MOV path
      default: rslt = in_b;
    endcase
  end

  assign zero = (rslt == '0);

endmodule

`default_nettype wire

// File: source/dat_mem.sv
// 256-byte data memory; clocked store, combinational load
`default_nettype none

module dat_mem (
  input  wire logic               clk,
  input  wire logic               we,
  input  wire cpu_pkg::mem_addr_t addr,    // from mem_lut
  input  wire cpu_pkg::word_t     wr_data, // register port a
  output cpu_pkg::word_t          rd_data
);
  import cpu_pkg::*;

  word_t mem [2**$bits(mem_addr_t)];

  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wr_data;
  end

  assign rd_data = mem[addr];

endmodule

`default_nettype wire

// File: source/cpu_top.sv
// processor top level; wires fetch, decode, registers, ALU and data memory, holds flags and output
`default_nettype none

module cpu_top #(
  parameter int PC_W = 6  // instruction memory holds 2**PC_W words
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            load_en,
  input  wire logic [PC_W-1:0] load_addr,
  input  wire cpu_pkg::instr_t load_instr,
  input  wire logic            req,
  output logic                 done,
  output logic                 out_valid,
  output cpu_pkg::word_t       out_data
);
  import cpu_pkg::*;

  logic [PC_W-1:0] pc;
  logic            run;
  instr_t          instr;
  instr_fields_t   instr_f;
  reg_addr_t       rd_a, rd_b, wr_addr;
  logic            reg_we;
  alu_cmd_e        alu_cmd;
  logic            imm_sel, mem_sel, mem_we;
  word_t           imm;
  mem_addr_t       mem_addr;
  logic            branch_en, halt, out_en;
  offset_t         branch_off;
  word_t           dat_a, dat_b, rslt, mem_rd, wr_data;
  logic            sc_out, zero;
  logic            sc_q, zero_q;  // registered flags
  logic            sc_en, zero_en, sc_clr;

  prog_ctr #(.PC_W(PC_W)) pc1 (
    .clk, .rst_n, .req, .halt, .branch_en, .branch_off, .pc, .run
  );

  instr_mem #(.PC_W(PC_W)) im1 (
    .clk, .load_en, .load_addr, .load_instr, .pc, .instr
  );

  ctrl_decode dec1 (
    .instr, .run, .zero_q, .rd_a, .rd_b, .wr_addr, .reg_we, .alu_cmd,
    .imm_sel, .imm, .mem_sel, .mem_addr, .mem_we, .branch_en, .branch_off,
    .halt, .out_en
  );

  reg_file rf1 (
    .clk, .rst_n, .we(reg_we), .rd_a, .rd_b, .wr_addr, .wr_data, .dat_a, .dat_b
  );

  alu alu1 (
    .alu_cmd, .in_a(dat_a), .in_b(dat_b), .sc_in(sc_q), .rslt, .sc_out, .zero
  );

  dat_mem dm1 (
    .clk, .we(mem_we), .addr(mem_addr), .wr_data(dat_a), .rd_data(mem_rd)
  );

  // write-back select
  assign wr_data = imm_sel ? imm : (mem_sel ? mem_rd : rslt);

  // flag enables follow the ALU command of a register write
  assign instr_f = instr_fields_t'(instr);
  assign sc_clr  = run && (instr_f.op == SHF) && (instr_f.b == 3'd2);
  assign sc_en   = reg_we && (alu_cmd inside {ALU_ADD, ALU_SHL, ALU_SHR});
  assign zero_en = reg_we && (alu_cmd inside {ALU_ADD, ALU_XOR, ALU_SHL, ALU_SHR});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sc_q   <= 1'b0;
      zero_q <= 1'b0;
    end else begin
      if (sc_clr)
        sc_q <= 1'b0;
      else if (sc_en)
        sc_q <= sc_out;
      if (zero_en)
        zero_q <= zero;
    end
  end

  // done set by halt, cleared by the next start
  always_ff @(posedge clk) begin
    if (!rst_n)
      done <= 1'b0;
    else if (req)
      done <= 1'b0;
    else if (halt)
      done <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= out_en; // one-cycle strobe
  end

  always_ff @(posedge clk) begin
    if (out_en)
      out_data <= dat_b; // r[b] of the OUT
  end

endmodule

`default_nettype wire

// File: testbench/cpu_props.sv
// concurrent checks on done, out_valid and the program counter; bound into every cpu_top
`default_nettype none

module cpu_props #(
  parameter int PC_W = 6
) (
  input wire logic            clk,
  input wire logic            rst_n,
  input wire logic            req,
  input wire logic            run,
  input wire logic            done,
  input wire logic            out_valid,
  input wire logic [PC_W-1:0] pc
);
  timeunit 1ns;
  timeprecision 100ps;

  // outputs quiet once reset has been applied
  assert property (@(posedge clk) !rst_n |=> !done && !out_valid)
    else $error("done or out_valid high after reset");

  assert property (@(posedge clk) disable iff (!rst_n) $rose(done) |-> $past(run))
    else $error("done rose without a run before it");

  // idle machine keeps its pc
  assert property (@(posedge clk) disable iff (!rst_n) !run && !req |=> $stable(pc))
    else $error("pc moved while idle");

  assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
    else $error("out_valid high for two cycles");

endmodule

bind cpu_top cpu_props #(.PC_W(PC_W)) props1 (
  .clk, .rst_n, .req, .run, .done, .out_valid, .pc
);

`default_nettype wire

// File: testbench/cpu_tb.sv
// testbench for cpu_top; loads directed programs, runs them and checks the OUT byte stream
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  localparam int PC_W      = 6;
  localparam int NUM_TESTS = 6;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            load_en;
  logic [PC_W-1:0] load_addr;
  instr_t          load_instr;
  logic            req;
  logic            done;
  logic            out_valid;
  word_t           out_data;

  instr_t prog[$];  // program being built
  word_t  outs[$];  // bytes seen on the OUT strobe
  word_t  exp_q[$]; // bytes the program should produce
  integer seed = 32'hf490_3928;

  cpu_top #(.PC_W(PC_W)) UUT (
    .clk, .rst_n, .load_en, .load_addr, .load_instr, .req, .done, .out_valid, .out_data
  );

  always #4 clk = ~clk; // 8 ns period

  // machine word from opcode and the two fields
  function automatic instr_t enc(opcode_e op, reg_addr_t a, reg_addr_t b);
    return {op, a, b};
  endfunction

  function automatic instr_t ldi(int imm);
    return {LDI, imm[5:0]}; // six-bit immediate into r0
  endfunction

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(posedge clk);
      load_en    <= 1'b1;
      load_addr  <= PC_W'(i);
      load_instr <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // start pulse, then gather strobes until done
  task automatic run_program();
    outs.delete();
    @(posedge clk);
    req <= 1'b1;
    @(posedge clk);
    req <= 1'b0;
    @(posedge clk);
    check("done", 0, done); // dropped by req
    while (!done) begin
      @(posedge clk);
      if (out_valid)
        outs.push_back(out_data);
    end
  endtask

  task automatic run_and_compare();
    load_program();
    run_program();
    check("out count", exp_q.size(), outs.size());
    foreach (exp_q[i])
      check($sformatf("out_data[%0d]", i), exp_q[i], outs[i]);
  endtask

  task automatic test_basic();
    prog  = '{ldi(5), enc(MOV, 1, 0), enc(CTL, 1, 1), ldi(42),
              enc(CTL, 1, 0), enc(MOV, 2, 0), enc(CTL, 1, 2), enc(CTL, 0, 0)};
    exp_q = '{8'd5, 8'd42, 8'd42};
    run_and_compare();
    @(posedge clk);
    check("done", 1, done); // level holds after halt
  endtask

  task automatic test_arith();
    int a;
    int b;
    int carry;
    a     = $random(seed) & 63;
    b     = $random(seed) & 63;
    carry = (252 + a) > 255; // r5 = 252 below
    prog  = '{enc(SHF, 0, 2), ldi(a), enc(MOV, 1, 0), ldi(b), enc(MOV, 2, 0),
              enc(MOV, 3, 1), enc(ADD, 3, 2), enc(CTL, 1, 3),
              enc(MOV, 4, 1), enc(XOR, 4, 2), enc(CTL, 1, 4),
              enc(SHF, 0, 2), ldi(63), enc(MOV, 5, 0), enc(SHF, 5, 0), enc(SHF, 5, 0),
              enc(ADD, 5, 1), enc(CTL, 1, 5),
              enc(MOV, 6, 2), enc(SHF, 6, 0), enc(CTL, 1, 6), enc(CTL, 0, 0)};
    exp_q = '{word_t'(a + b), word_t'(a ^ b), word_t'(252 + a), word_t'((b << 1) | carry)};
    run_and_compare();
  endtask

  // chain of shifts, expected bytes from the sc rotate rule
  task automatic test_shifts();
    int    modes[$] = '{2, 0, 0, 0, 1, 0, 0, 0, 2, 1};
    word_t v        = 8'h2d;
    logic  sc       = 1'b0;
    logic  nxt_sc;
    prog  = '{ldi(v), enc(MOV, 1, 0)};
    exp_q = {};
    foreach (modes[i]) begin
      prog.push_back(enc(SHF, 1, 3'(modes[i])));
      if (modes[i] == 0) begin
        nxt_sc = v[7];              // msb falls out
        v      = (v << 1) | sc;     // sc into bit 0
        sc     = nxt_sc;
      end else if (modes[i] == 1) begin
        nxt_sc = v[0];              // lsb falls out
        v      = (v >> 1) | {sc, 7'b0}; // sc into bit 7
        sc     = nxt_sc;
      end else begin
        sc = 1'b0;
      end
      if (modes[i] != 2) begin
        prog.push_back(enc(CTL, 1, 1));
        exp_q.push_back(v);
      end
    end
    prog.push_back(enc(CTL, 0, 0));
    run_and_compare();
  endtask

  task automatic test_mem();
    prog  = '{ldi(11), enc(MOV, 1, 0), ldi(22), enc(MOV, 2, 0),
              ldi(33), enc(MOV, 3, 0), ldi(44), enc(MOV, 4, 0),
              enc(ST, 1, 0), enc(ST, 2, 4), enc(ST, 3, 6), enc(ST, 4, 7), // 0, 16, 128, 255
              enc(LD, 5, 7), enc(CTL, 1, 5), enc(LD, 6, 0), enc(CTL, 1, 6),
              enc(LD, 7, 6), enc(CTL, 1, 7), enc(LD, 1, 4), enc(CTL, 1, 1),
              enc(CTL, 0, 0)};
    exp_q = '{8'd44, 8'd11, 8'd33, 8'd22};
    run_and_compare();
  endtask

  task automatic test_branch();
    prog  = '{enc(SHF, 0, 2), ldi(63), enc(MOV, 2, 0), enc(SHF, 2, 0), enc(SHF, 2, 0),
              ldi(3), enc(ADD, 2, 0),            // r2 = 255, acts as minus one
              ldi(55), enc(MOV, 3, 0),           // byte that must be skipped
              ldi(4), enc(MOV, 1, 0),
              enc(CTL, 1, 1), enc(ADD, 1, 2), enc(CTL, 2, 1), // out, dec, bnz -2
              enc(CTL, 3, 4), enc(CTL, 1, 3),    // bra +2 over the OUT of r3
              enc(CTL, 1, 1), enc(CTL, 0, 0)};
    exp_q = {};
    for (int n = 4; n >= 0; n--)
      exp_q.push_back(word_t'(n));
    run_and_compare();
  endtask

  // new program from address 0, registers kept from earlier runs
  task automatic test_restart();
    check("done", 1, done);
    prog  = '{enc(CTL, 1, 6), enc(MOV, 0, 7), enc(CTL, 1, 0),
              enc(MOV, 0, 2), enc(CTL, 1, 0), enc(CTL, 0, 0)};
    exp_q = '{8'd11, 8'd33, 8'd255};
    run_and_compare();
    check("done", 1, done);
  endtask

  initial begin
    rst_n      <= 1'b0;
    load_en    <= 1'b0;
    load_addr  <= '0;
    load_instr <= '0;
    req        <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_basic();
    test_arith();
    test_shifts();
    test_mem();
    test_branch();
    test_restart();
    $display("Simulation finished: PASS");
    $finish;
  end

  // hang guard, 200 cycles per test plus reset
  initial begin
    repeat (200 * NUM_TESTS + 8) @(posedge clk);
    $display("timeout: the processor did not finish its programs in time");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// File: tb.f
source/cpu_pkg.sv
source/prog_ctr.sv
source/instr_mem.sv
source/ctrl_decode.sv
source/reg_file.sv
source/alu.sv
source/dat_mem.sv
source/cpu_top.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
    -Mdir obj_dir -f tb.f; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1
